//--- Makefile
# Verilator build and run for the cache memory system

VERILATOR ?= verilator
TOP       ?= tb_mem_system
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Regression passed

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard bench/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Every failed check ends up here
task automatic stop_on_failure(input string why);
	$display("%s", why);
	$display("Regression failed");
	$fatal(1);
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
	if (got !== exp)
		stop_on_failure($sformatf("Error: %s got %h, expected %h", name, got, exp));
endtask

task automatic check_latency(input string name, input int got, input int exp);
	if (got != exp)
		stop_on_failure($sformatf("Error: %s latency got %0h, expected %0h", name, got, exp));
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp)
		stop_on_failure($sformatf("Error: %s got %h, expected %h", name, got, exp));
endtask

// Counts cycles from the request cycle to done on falling edges
task automatic wait_done(input int limit, output int cycles, output word_t rdata,
		output logic hit_flag);
	int n;
	logic seen;
	n = 0;
	seen = 1'b0;
	rdata = '0;
	hit_flag = 1'b0;
	while (!seen && n < limit) begin
		@(negedge clk);
		n++;
		if (done) begin
			seen = 1'b1;
			rdata = data_out;
			hit_flag = cache_hit;
		end
	end
	if (!seen)
		stop_on_failure($sformatf("Timeout: no done within %0d cycles of the request", limit));
	cycles = n;
endtask

`endif

//--- bench/tb_mem_system.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_system import mem_pkg::*; ();

	localparam int HIT_LATENCY = 0;
	localparam int CLEAN_MISS_LATENCY = 8;
	localparam int DIRTY_MISS_LATENCY = 12;  // Four write-back cycles on top
	localparam int DONE_TIMEOUT = 24;
	localparam int RANDOM_OPS = 200;

	logic clk;
	logic arst_n;
	addr_t addr;
	word_t data_in;
	logic rd;
	logic wr;
	word_t data_out;
	logic done;
	logic stall;
	logic cache_hit;
	logic err;

	integer seed;

	// Architectural memory contents where a missing key reads as zero
	word_t mem_model [addr_t];

	// Cache state model per way and set
	bit model_valid [2][256];
	bit model_dirty [2][256];
	tag_t model_tag [2][256];
	bit model_mru0 [256];

	mem_system #(.MEM_ADDR_BITS(16)) mem_system_i (
		.clk(clk),
		.arst_n(arst_n),
		.addr(addr),
		.data_in(data_in),
		.rd(rd),
		.wr(wr),
		.data_out(data_out),
		.done(done),
		.stall(stall),
		.cache_hit(cache_hit),
		.err(err)
	);

	always #4 clk = ~clk;

	`include "tb_checks.svh"

	function automatic addr_t make_addr(input tag_t t, input index_t i, input offset_t o);
		return {t, i, o};
	endfunction

	function automatic word_t model_word(input addr_t a);
		return mem_model.exists(a) ? mem_model[a] : '0;
	endfunction

	function automatic int find_hit_way(input addr_t a);
		for (int w = 0; w < 2; w++)
			if (model_valid[w][a[10:3]] && model_tag[w][a[10:3]] == a[15:11])
				return w;
		return -1;  // Miss
	endfunction

	function automatic int pick_victim(input index_t i);
		if (!model_valid[0][i])
			return 0;
		else if (!model_valid[1][i])
			return 1;
		else if (model_mru0[i])
			return 1;
		return 0;
	endfunction

	function automatic int expected_latency(input addr_t a);
		if (find_hit_way(a) >= 0)
			return HIT_LATENCY;
		return model_dirty[pick_victim(a[10:3])][a[10:3]] ? DIRTY_MISS_LATENCY
			: CLEAN_MISS_LATENCY;
	endfunction

	function automatic void update_model(input logic is_write, input addr_t a, input word_t d);
		int w;
		index_t i;
		i = a[10:3];
		w = find_hit_way(a);
		if (w < 0) begin
			w = pick_victim(i);  // Refill replaces the victim line
			model_valid[w][i] = 1'b1;
			model_tag[w][i] = a[15:11];
			model_dirty[w][i] = 1'b0;
		end
		if (is_write) begin
			model_dirty[w][i] = 1'b1;
			mem_model[a] = d;
		end
		model_mru0[i] = (w == 0);
	endfunction

	// Issues one request and checks latency, hit flag and read data
	task automatic do_access(input logic is_write, input addr_t a, input word_t d,
			input int exp_latency);
		word_t got_data;
		logic got_hit;
		logic exp_hit;
		logic done_now;
		int latency;
		exp_hit = (exp_latency == HIT_LATENCY);
		@(posedge clk);
		addr <= a;
		data_in <= d;
		rd <= ~is_write;
		wr <= is_write;
		@(negedge clk);
		check_flag("err", err, 1'b0);
		check_flag("stall", stall, ~exp_hit);
		done_now = done;
		latency = 0;
		got_data = data_out;
		got_hit = cache_hit;
		@(posedge clk);
		rd <= 1'b0;
		wr <= 1'b0;
		if (!done_now)
			wait_done(DONE_TIMEOUT, latency, got_data, got_hit);
		check_latency("done", latency, exp_latency);
		check_flag("cache_hit", got_hit, exp_hit);
		if (!is_write)
			check_word("data_out", got_data, model_word(a));
		update_model(is_write, a, d);
	endtask

	task automatic issue_bad_request(input logic rd_v, input logic wr_v, input addr_t a,
			input word_t d);
		@(posedge clk);
		addr <= a;
		data_in <= d;
		rd <= rd_v;
		wr <= wr_v;
		@(negedge clk);
		check_flag("err", err, 1'b1);
		check_flag("stall", stall, 1'b0);
		check_flag("done", done, 1'b0);
		@(posedge clk);
		rd <= 1'b0;
		wr <= 1'b0;
		repeat (4) begin  // Dropped request must stay quiet
			@(negedge clk);
			check_flag("done", done, 1'b0);
			check_flag("stall", stall, 1'b0);
		end
	endtask

	task automatic test_cold_write();
		do_access(1'b1, make_addr(5'd1, 8'd5, 3'd2), 16'ha5a5, CLEAN_MISS_LATENCY);
		do_access(1'b0, make_addr(5'd1, 8'd5, 3'd2), 16'h0000, HIT_LATENCY);
	endtask

	task automatic test_same_set();
		do_access(1'b1, make_addr(5'd2, 8'd9, 3'd4), 16'h1234, CLEAN_MISS_LATENCY);
		do_access(1'b1, make_addr(5'd3, 8'd9, 3'd4), 16'h5678, CLEAN_MISS_LATENCY);
		do_access(1'b0, make_addr(5'd2, 8'd9, 3'd4), 16'h0000, HIT_LATENCY);
		do_access(1'b0, make_addr(5'd3, 8'd9, 3'd4), 16'h0000, HIT_LATENCY);
	endtask

	// Tag 2 in way 0 goes out dirty since way 1 was used last
	task automatic test_dirty_eviction();
		do_access(1'b1, make_addr(5'd4, 8'd9, 3'd4), 16'h9abc, DIRTY_MISS_LATENCY);
		do_access(1'b0, make_addr(5'd2, 8'd9, 3'd4), 16'h0000, DIRTY_MISS_LATENCY);
	endtask

	task automatic test_clean_eviction();
		do_access(1'b0, make_addr(5'd1, 8'd20, 3'd0), 16'h0000, CLEAN_MISS_LATENCY);
		do_access(1'b0, make_addr(5'd2, 8'd20, 3'd6), 16'h0000, CLEAN_MISS_LATENCY);
		do_access(1'b0, make_addr(5'd3, 8'd20, 3'd2), 16'h0000, CLEAN_MISS_LATENCY);
		do_access(1'b0, make_addr(5'd1, 8'd20, 3'd0), 16'h0000, CLEAN_MISS_LATENCY);
		do_access(1'b0, make_addr(5'd3, 8'd20, 3'd2), 16'h0000, HIT_LATENCY);
	endtask

	task automatic test_bad_requests();
		issue_bad_request(1'b0, 1'b1, make_addr(5'd1, 8'd5, 3'd3), 16'hdead);
		issue_bad_request(1'b1, 1'b1, make_addr(5'd1, 8'd5, 3'd2), 16'hbeef);
		do_access(1'b0, make_addr(5'd1, 8'd5, 3'd2), 16'h0000, HIT_LATENCY);
	endtask

	task automatic test_random();
		logic [31:0] r;
		addr_t a;
		for (int n = 0; n < RANDOM_OPS; n++) begin
			r = $random(seed);
			a = make_addr({2'b00, r[2:0]}, 8'd40 + {6'd0, r[4:3]}, {r[6:5], 1'b0});
			do_access(r[7], a, r[31:16], expected_latency(a));
		end
	endtask

	initial begin
		seed = 32'h7ef3_5a1d;
		clk = 1'b0;
		arst_n = 1'b0;
		addr = '0;
		data_in = '0;
		rd = 1'b0;
		wr = 1'b0;
		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_flag("done", done, 1'b0);
		check_flag("stall", stall, 1'b0);
		check_flag("cache_hit", cache_hit, 1'b0);
		check_flag("err", err, 1'b0);

		test_cold_write();
		test_same_set();
		test_dirty_eviction();
		test_clean_eviction();
		test_bad_requests();
		test_random();

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+bench
hw/mem_pkg.sv
hw/cache_line_if.sv
hw/mem_bus_if.sv
hw/cache_way.sv
hw/lru_table.sv
hw/cache_controller.sv
hw/main_memory.sv
hw/mem_system.sv
bench/tb_mem_system.sv

//--- hw/cache_controller.sv
`default_nettype none
`timescale 1ns/1ns

module cache_controller import mem_pkg::*; (
	input wire clk,
	input wire arst_n,
	input wire addr_t addr,
	input wire word_t data_in,
	input wire rd,
	input wire wr,
	output word_t data_out,
	output logic done,
	output logic stall,
	output logic cache_hit,
	output logic err,
	cache_line_if.ctrl way0,
	cache_line_if.ctrl way1,
	mem_bus_if.ctrl mem,
	output index_t lru_index,
	output logic lru_update,
	output logic lru_used_way0,
	input wire lru_mru_way0
);

	ctrl_state_t state, next_state;

	addr_t req_addr;  // Latched miss request
	word_t req_data;
	logic req_wr;
	way_sel_t victim;
	way_sel_t victim_pick;

	addr_t acc_addr;
	word_t acc_data;
	tag_t acc_tag;
	index_t acc_index;
	offset_t acc_offset;

	logic req_bad, req_valid, any_hit;
	logic wb_needed;
	way_sel_t way_en;
	logic way_comp, way_write, data_src;
	offset_t way_offset, mem_offset;
	tag_t mem_tag;
	logic mem_rd, mem_wr;

	tag_t sel_tag;
	word_t sel_rdata;

	// Idle serves the live request and later states the latched one
	assign acc_addr = (state == idle) ? addr : req_addr;
	assign acc_data = (state == idle) ? data_in : req_data;
	assign acc_tag = acc_addr[15:11];
	assign acc_index = acc_addr[10:3];
	assign acc_offset = acc_addr[2:0];

	assign req_bad = (rd | wr) & (addr[0] | (rd & wr));
	assign req_valid = (rd | wr) & ~req_bad;
	assign any_hit = way0.hit | way1.hit;

	assign sel_tag = victim[0] ? way0.tag_out : way1.tag_out;
	assign sel_rdata = victim[0] ? way0.rdata : way1.rdata;

	// Invalid way first and then the one not used last
	always_comb begin
		if (!way0.valid)
			victim_pick = 2'b01;
		else if (!way1.valid)
			victim_pick = 2'b10;
		else if (lru_mru_way0)
			victim_pick = 2'b10;
		else
			victim_pick = 2'b01;
	end

	assign wb_needed = victim_pick[0] ? (way0.valid & way0.dirty) : (way1.valid & way1.dirty);

	// Both ways see the same index, offset, tag and data
	assign way0.enable = way_en[0];
	assign way1.enable = way_en[1];
	assign way0.index = acc_index;
	assign way1.index = acc_index;
	assign way0.offset = way_offset;
	assign way1.offset = way_offset;
	assign way0.tag_in = acc_tag;
	assign way1.tag_in = acc_tag;
	assign way0.wdata = data_src ? mem.rdata : acc_data;
	assign way1.wdata = data_src ? mem.rdata : acc_data;
	assign way0.comp = way_comp;
	assign way1.comp = way_comp;
	assign way0.write = way_write;
	assign way1.write = way_write;

	assign mem.addr = {mem_tag, acc_index, mem_offset};
	assign mem.wdata = sel_rdata;  // Write-back word from the victim
	assign mem.rd = mem_rd;
	assign mem.wr = mem_wr;

	assign lru_index = acc_index;
	assign data_out = (state == idle) ? (way0.hit ? way0.rdata : way1.rdata) : sel_rdata;

	always_comb begin
		next_state = state;
		done = 1'b0;
		stall = 1'b1;
		cache_hit = 1'b0;
		err = 1'b0;
		way_en = 2'b00;
		way_comp = 1'b0;
		way_write = 1'b0;
		data_src = 1'b0;
		way_offset = acc_offset;
		mem_offset = 3'd0;
		mem_tag = acc_tag;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		lru_update = 1'b0;
		lru_used_way0 = 1'b0;
		case (state)
		idle: begin
			stall = 1'b0;
			way_comp = 1'b1;
			err = req_bad;
			if (req_valid) begin
				way_en = 2'b11;
				way_write = wr;  // Lands only in the way that hits
				if (any_hit) begin
					done = 1'b1;
					cache_hit = 1'b1;
					lru_update = 1'b1;
					lru_used_way0 = way0.hit;
				end else begin
					stall = 1'b1;
					next_state = victim_select;
				end
			end
		end
		victim_select: next_state = wb_needed ? writeback_0 : request_0;
		writeback_0, writeback_1, writeback_2, writeback_3: begin
			way_en = victim;
			mem_tag = sel_tag;
			mem_wr = 1'b1;
			case (state)
			writeback_0: begin
				way_offset = 3'd0;
				next_state = writeback_1;
			end
			writeback_1: begin
				way_offset = 3'd2;
				next_state = writeback_2;
			end
			writeback_2: begin
				way_offset = 3'd4;
				next_state = writeback_3;
			end
			default: begin
				way_offset = 3'd6;
				next_state = request_0;
			end
			endcase
			mem_offset = way_offset;
		end
		request_0: begin
			mem_rd = 1'b1;
			mem_offset = 3'd0;
			next_state = request_1;
		end
		request_1: begin
			mem_rd = 1'b1;
			mem_offset = 3'd2;
			next_state = request_2;
		end
		request_2, request_3, fill_2, fill_3: begin
			way_en = victim;  // Access mode write of a fetched word
			way_write = 1'b1;
			data_src = 1'b1;
			case (state)
			request_2: begin
				mem_rd = 1'b1;
				mem_offset = 3'd4;
				way_offset = 3'd0;
				next_state = request_3;
			end
			request_3: begin
				mem_rd = 1'b1;
				mem_offset = 3'd6;
				way_offset = 3'd2;
				next_state = fill_2;
			end
			fill_2: begin
				way_offset = 3'd4;
				next_state = fill_3;
			end
			default: begin
				way_offset = 3'd6;
				next_state = complete;
			end
			endcase
		end
		complete: begin
			// Replays the original access as a hit in the victim way
			stall = 1'b0;
			done = 1'b1;
			way_en = victim;
			way_comp = 1'b1;
			way_write = req_wr;
			lru_update = 1'b1;
			lru_used_way0 = victim[0];
			next_state = idle;
		end
		default: next_state = idle;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= idle;
			req_wr <= 1'b0;
			victim <= 2'b00;
		end else begin
			state <= next_state;
			if (state == idle && req_valid)
				req_wr <= wr;
			if (state == victim_select)
				victim <= victim_pick;
		end
	end

	always_ff @(posedge clk) begin
		if (state == idle && req_valid) begin
			req_addr <= addr;
			req_data <= data_in;
		end
	end

endmodule

`default_nettype wire

//--- hw/cache_line_if.sv
`default_nettype none
`timescale 1ns/1ns

interface cache_line_if import mem_pkg::*; ();

	logic    enable;
	index_t  index;
	offset_t offset;
	tag_t    tag_in;
	word_t   wdata;
	logic    comp;   // 1 compare mode, 0 access mode
	logic    write;

	logic    hit;
	logic    valid;
	logic    dirty;
	tag_t    tag_out;
	word_t   rdata;

	modport ctrl (output enable, index, offset, tag_in, wdata, comp, write,
		input hit, valid, dirty, tag_out, rdata);

	modport way (input enable, index, offset, tag_in, wdata, comp, write,
		output hit, valid, dirty, tag_out, rdata);

endinterface

`default_nettype wire

//--- hw/cache_way.sv
`default_nettype none
`timescale 1ns/1ns

module cache_way import mem_pkg::*; (
	input wire clk,
	input wire arst_n,
	cache_line_if.way port
);

	localparam int SETS = 256;
	localparam int WORD_BITS = $clog2(LINE_WORDS);

	tag_t  tag_mem [SETS];
	word_t data_mem [SETS * LINE_WORDS];
	logic [SETS-1:0] valid_bits;
	logic [SETS-1:0] dirty_bits;

	logic [WORD_BITS-1:0] word_sel;
	logic tag_match;
	logic wr_en;

	assign word_sel = port.offset[WORD_BITS:1];  // Drop the byte bit
	assign wr_en = port.enable & port.write;

	// Lookup is combinational on the current index
	assign port.valid = valid_bits[port.index];
	assign port.dirty = dirty_bits[port.index];
	assign port.tag_out = tag_mem[port.index];
	assign port.rdata = data_mem[{port.index, word_sel}];

	assign tag_match = (tag_mem[port.index] == port.tag_in);
	assign port.hit = port.comp & port.valid & tag_match;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (wr_en) begin
			if (port.comp) begin
				if (port.hit)
					dirty_bits[port.index] <= 1'b1;  // Requester write
			end else begin
				valid_bits[port.index] <= 1'b1;  // Refill word
				dirty_bits[port.index] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			if (!port.comp)
				tag_mem[port.index] <= port.tag_in;
			if (!port.comp || port.hit)
				data_mem[{port.index, word_sel}] <= port.wdata;
		end
	end

endmodule

`default_nettype wire

//--- hw/lru_table.sv
`default_nettype none
`timescale 1ns/1ns

module lru_table import mem_pkg::*; (
	input wire clk,
	input wire arst_n,
	input wire index_t index,
	input wire update,
	input wire used_way0,
	output logic mru_way0
);

	// One bit per set, high when way 0 was touched last
	logic [255:0] mru_bits;

	assign mru_way0 = mru_bits[index];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			mru_bits <= '0;
		else if (update)
			mru_bits[index] <= used_way0;
	end

endmodule

`default_nettype wire

//--- hw/main_memory.sv
`default_nettype none
`timescale 1ns/1ns

module main_memory import mem_pkg::*; #(
	parameter int MEM_ADDR_BITS = 16
) (
	input wire clk,
	input wire arst_n,
	mem_bus_if.mem bus
);

	localparam int BANK_BITS = $clog2(LINE_WORDS);
	localparam int ROW_BITS = MEM_ADDR_BITS - BANK_BITS - 1;
	localparam int BANK_DEPTH = 2 ** ROW_BITS;

	word_t bank_mem [LINE_WORDS][BANK_DEPTH];

	logic [BANK_BITS-1:0] addr_bank;
	logic [ROW_BITS-1:0] addr_row;

	// Read pipeline, stage 0 captures the request
	logic [BANK_BITS-1:0] rd_bank [MEM_READ_LATENCY];
	logic [ROW_BITS-1:0] rd_row [MEM_READ_LATENCY];
	logic [MEM_READ_LATENCY-1:0] rd_pending;

	// Word offset picks the bank, bits above MEM_ADDR_BITS alias
	assign addr_bank = bus.addr[BANK_BITS:1];
	assign addr_row = bus.addr[MEM_ADDR_BITS-1:BANK_BITS+1];

	initial begin
		for (int b = 0; b < LINE_WORDS; b++)
			for (int r = 0; r < BANK_DEPTH; r++)
				bank_mem[b][r] = '0;
	end

	always_ff @(posedge clk) begin
		if (bus.wr)
			bank_mem[addr_bank][addr_row] <= bus.wdata;
	end

	always_ff @(posedge clk) begin
		if (bus.rd) begin
			rd_bank[0] <= addr_bank;
			rd_row[0] <= addr_row;
		end
		for (int s = 1; s < MEM_READ_LATENCY; s++) begin
			rd_bank[s] <= rd_bank[s-1];
			rd_row[s] <= rd_row[s-1];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			rd_pending <= '0;
		else
			rd_pending <= {rd_pending[MEM_READ_LATENCY-2:0], bus.rd};
	end

	assign bus.rdata = rd_pending[MEM_READ_LATENCY-1] ?
		bank_mem[rd_bank[MEM_READ_LATENCY-1]][rd_row[MEM_READ_LATENCY-1]] : '0;

endmodule

`default_nettype wire

//--- hw/mem_bus_if.sv
`default_nettype none
`timescale 1ns/1ns

interface mem_bus_if import mem_pkg::*; ();

	addr_t addr;
	word_t wdata;
	logic  wr;
	logic  rd;
	word_t rdata;  // Valid MEM_READ_LATENCY cycles after rd

	modport ctrl (output addr, wdata, wr, rd, input rdata);

	modport mem (input addr, wdata, wr, rd, output rdata);

endinterface

`default_nettype wire

//--- hw/mem_pkg.sv
`default_nettype none

package mem_pkg;

	typedef logic [15:0] addr_t;    // Byte address
	typedef logic [15:0] word_t;
	typedef logic [4:0]  tag_t;     // addr[15:11]
	typedef logic [7:0]  index_t;   // addr[10:3], 256 sets
	typedef logic [2:0]  offset_t;  // addr[2:0], word aligned
	typedef logic [1:0]  way_sel_t; // One-hot, bit 0 is way 0

	localparam int LINE_WORDS = 4;

	// Refill schedule in the controller counts on this
	localparam int MEM_READ_LATENCY = 2;

	typedef enum logic [3:0] {
		idle,
		victim_select,
		writeback_0,
		writeback_1,
		writeback_2,
		writeback_3,
		request_0,
		request_1,
		request_2,  // Also fills word 0
		request_3,  // Also fills word 1
		fill_2,
		fill_3,
		complete
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/mem_system.sv
`default_nettype none
`timescale 1ns/1ns

module mem_system import mem_pkg::*; #(
	parameter int MEM_ADDR_BITS = 16
) (
	input wire clk,
	input wire arst_n,
	input wire addr_t addr,
	input wire word_t data_in,
	input wire rd,
	input wire wr,
	output word_t data_out,
	output logic done,
	output logic stall,
	output logic cache_hit,
	output logic err
);

	cache_line_if line0 ();
	cache_line_if line1 ();
	mem_bus_if bus ();

	index_t lru_index;
	logic lru_update;
	logic lru_used_way0;
	logic lru_mru_way0;

	cache_controller ctrl_i (
		.clk(clk),
		.arst_n(arst_n),
		.addr(addr),
		.data_in(data_in),
		.rd(rd),
		.wr(wr),
		.data_out(data_out),
		.done(done),
		.stall(stall),
		.cache_hit(cache_hit),
		.err(err),
		.way0(line0.ctrl),
		.way1(line1.ctrl),
		.mem(bus.ctrl),
		.lru_index(lru_index),
		.lru_update(lru_update),
		.lru_used_way0(lru_used_way0),
		.lru_mru_way0(lru_mru_way0)
	);

	cache_way way0_i (.clk(clk), .arst_n(arst_n), .port(line0.way));
	cache_way way1_i (.clk(clk), .arst_n(arst_n), .port(line1.way));

	lru_table lru_i (
		.clk(clk),
		.arst_n(arst_n),
		.index(lru_index),
		.update(lru_update),
		.used_way0(lru_used_way0),
		.mru_way0(lru_mru_way0)
	);

	main_memory #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) mem_i (
		.clk(clk),
		.arst_n(arst_n),
		.bus(bus.mem)
	);

endmodule

`default_nettype wire
